/* hw/soc_io_pkg.sv */
package soc_io_pkg;

  // Only the low address bits select a register
  // Upper bits alias onto the same five words
  localparam int io_addr_bits = 8;

  // Byte offsets of the word registers
  localparam logic [io_addr_bits-1:0] reg_uart_data   = 8'h00;
  localparam logic [io_addr_bits-1:0] reg_uart_status = 8'h04;
  localparam logic [io_addr_bits-1:0] reg_led         = 8'h08;
  localparam logic [io_addr_bits-1:0] reg_gpio        = 8'h0C;
  // Read-only system clock in Hz
  localparam logic [io_addr_bits-1:0] reg_clk_freq    = 8'h10;

  // Bit positions in the UART status word
  // Queue can take another byte
  localparam int stat_tx_ready    = 0;
  // Queue empty and serializer idle
  localparam int stat_tx_idle     = 1;
  // Sticky flag for a byte dropped on a full queue
  localparam int stat_tx_overflow = 2;

  // Read timing of the register file
  typedef enum logic {
    // Combinational read with data in the same cycle
    mem_sram = 1'b0,
    // Registered read with data one cycle after the address
    mem_bram = 1'b1
  } mem_type_e;

endpackage

/* hw/io_wr_if.sv */
interface io_wr_if;

  // One-cycle strobes from the decode stage
  logic       led_we;
  logic       gpio_we;
  logic       tx_we;
  // Any write to the status offset
  logic       status_clr;

  // Low data byte latched with the strobes
  logic [7:0] wr_byte;

  // Decode stage drives everything
  modport src (
    output led_we,
    output gpio_we,
    output tx_we,
    output status_clr,
    output wr_byte
  );

  // Register bank side
  modport regs (
    input led_we,
    input gpio_we,
    input status_clr,
    input wr_byte
  );

  // Transmit queue side
  modport queue (
    input tx_we,
    input wr_byte
  );

endinterface

/* hw/io_write_decode.sv */
module io_write_decode (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        io_wen,
  input  logic [31:0] io_waddr,
  input  logic [31:0] io_wdata,
  input  logic [3:0]  io_wstrb,
  io_wr_if.src        wr
);

  // Offset within the I/O window
  logic [soc_io_pkg::io_addr_bits-1:0] waddr_low;
  // Accepted write needs lane 0 enabled
  logic                                wr_fire;

  assign waddr_low = io_waddr[soc_io_pkg::io_addr_bits-1:0];

  // Upper lanes carry nothing
  // Every register fits in a byte
  assign wr_fire = io_wen && io_wstrb[0];

  // One-hot strobes high for the cycle after the write is sampled
  // Frequency and unmapped offsets match nothing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr.led_we     <= 1'b0;
      wr.gpio_we    <= 1'b0;
      wr.tx_we      <= 1'b0;
      wr.status_clr <= 1'b0;
    end else begin
      wr.led_we     <= wr_fire && (waddr_low == soc_io_pkg::reg_led);
      wr.gpio_we    <= wr_fire && (waddr_low == soc_io_pkg::reg_gpio);
      wr.tx_we      <= wr_fire && (waddr_low == soc_io_pkg::reg_uart_data);
      wr.status_clr <= wr_fire && (waddr_low == soc_io_pkg::reg_uart_status);
    end
  end

  // Data byte travels alongside the strobes
  // Only meaningful while one of them is high
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      wr.wr_byte <= io_wdata[7:0];
    end
  end

endmodule

/* hw/io_ctrl_regs.sv */
module io_ctrl_regs #(
  parameter int                    CLOCK_FREQ = 25_000_000,
  parameter soc_io_pkg::mem_type_e MEM_TYPE   = soc_io_pkg::mem_bram
) (
  input  logic        clk,
  input  logic        rst_n,
  io_wr_if.regs       wr,
  input  logic        io_ren,
  input  logic [31:0] io_raddr,
  input  logic        q_not_full,
  input  logic        q_empty,
  input  logic        q_overflow,
  input  logic        tx_busy,
  output logic [31:0] io_rdata,
  output logic        led,
  output logic [7:0]  gpio
);

  logic                                led_reg;
  logic [7:0]                          gpio_reg;
  // Sticky drop flag for the transmit queue
  logic                                overflow_flag;
  logic [31:0]                         status_word;
  logic [soc_io_pkg::io_addr_bits-1:0] raddr_low;
  // Read word before the timing stage
  logic [31:0]                         rdata_comb;

  // Output registers written one cycle after the bus write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_reg  <= 1'b0;
      gpio_reg <= 8'h00;
    end else begin
      if (wr.led_we) begin
        led_reg <= wr.wr_byte[0];
      end
      if (wr.gpio_we) begin
        gpio_reg <= wr.wr_byte;
      end
    end
  end

  assign led  = led_reg;
  assign gpio = gpio_reg;

  // A fresh drop wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      overflow_flag <= 1'b0;
    end else if (q_overflow) begin
      overflow_flag <= 1'b1;
    end else if (wr.status_clr) begin
      overflow_flag <= 1'b0;
    end
  end

  // Status word as software sees it
  always_comb begin
    status_word = 32'h0;
    status_word[soc_io_pkg::stat_tx_ready]    = q_not_full;
    // Idle means nothing queued and nothing on the wire
    status_word[soc_io_pkg::stat_tx_idle]     = q_empty && !tx_busy;
    status_word[soc_io_pkg::stat_tx_overflow] = overflow_flag;
  end

  assign raddr_low = io_raddr[soc_io_pkg::io_addr_bits-1:0];

  // Read mux returns zero when not reading
  // Data offset is write-only and reads zero
  always_comb begin
    rdata_comb = 32'h0;
    if (io_ren) begin
      case (raddr_low)
        soc_io_pkg::reg_uart_status: rdata_comb = status_word;
        soc_io_pkg::reg_led:         rdata_comb = {31'h0, led_reg};
        soc_io_pkg::reg_gpio:        rdata_comb = {24'h0, gpio_reg};
        soc_io_pkg::reg_clk_freq:    rdata_comb = 32'(CLOCK_FREQ);
        default:                     rdata_comb = 32'h0;
      endcase
    end
  end

  // Read latency follows the memory type of the core
  if (MEM_TYPE == soc_io_pkg::mem_bram) begin : g_bram_read
    // One-cycle registered read
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        io_rdata <= 32'h0;
      end else begin
        io_rdata <= rdata_comb;
      end
    end
  end else begin : g_sram_read
    // Same-cycle read
    assign io_rdata = rdata_comb;
  end

endmodule

/* hw/uart_tx_queue.sv */
module uart_tx_queue #(
  parameter int TX_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  io_wr_if.queue     wr,
  output logic       tx_valid,
  output logic [7:0] tx_data,
  input  logic       tx_ready,
  output logic       not_full,
  output logic       empty,
  output logic       overflow_pulse
);

  // Index width for a power-of-two depth
  localparam int AW = $clog2(TX_DEPTH);

  logic [7:0]  mem [TX_DEPTH];
  // Extra top bit tells full from empty
  logic [AW:0] wptr;
  logic [AW:0] rptr;
  logic        full;
  logic        push;
  logic        pop;

  assign empty = (wptr == rptr);
  // Same index with opposite wrap bits
  assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

  assign not_full = !full;

  // A full queue refuses the byte even if a pop is in progress
  assign push           = wr.tx_we && !full;
  assign overflow_pulse = wr.tx_we && full;

  // Byte moves out when the serializer is idle
  assign pop = tx_valid && tx_ready;

  assign tx_valid = !empty;
  assign tx_data  = mem[rptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr[AW-1:0]] <= wr.wr_byte;
    end
  end

endmodule

/* hw/uart_tx_serializer.sv */
module uart_tx_serializer #(
  parameter int CLOCK_FREQ = 25_000_000,
  parameter int BAUD_RATE  = 115_200
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_valid,
  input  logic [7:0] tx_data,
  output logic       tx_ready,
  output logic       busy,
  output logic       uart_tx
);

  // Clock cycles spent on each bit after truncation
  localparam int CYCLES_PER_BIT = CLOCK_FREQ / BAUD_RATE;
  localparam int CNT_W          = $clog2(CYCLES_PER_BIT + 1);
  // Start, eight data bits, stop
  localparam int FRAME_BITS     = 10;

  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  // Bit 0 drives the line
  // Ones shift in behind the frame
  logic [9:0]       shift_reg;
  logic             busy_q;
  logic             bit_done;
  logic             accept;

  assign busy     = busy_q;
  // Takes a byte only between frames
  assign tx_ready = !busy_q;
  assign accept   = tx_valid && !busy_q;

  assign bit_done = (baud_cnt == CNT_W'(CYCLES_PER_BIT - 1));

  // Line comes straight from a flop
  assign uart_tx = shift_reg[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      // Idle line is high
      shift_reg <= '1;
    end else if (accept) begin
      busy_q    <= 1'b1;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      // Stop, data LSB first, start
      shift_reg <= {1'b1, tx_data, 1'b0};
    end else if (busy_q) begin
      if (bit_done) begin
        baud_cnt  <= '0;
        shift_reg <= {1'b1, shift_reg[9:1]};
        // Frame ends after the full stop bit
        if (bit_cnt == 4'(FRAME_BITS - 1)) begin
          busy_q <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

/* hw/soc_io_top.sv */
module soc_io_top #(
  parameter int                    CLOCK_FREQ = 25_000_000,
  parameter int                    BAUD_RATE  = 115_200,
  parameter soc_io_pkg::mem_type_e MEM_TYPE   = soc_io_pkg::mem_bram,
  // Power of two
  parameter int                    TX_DEPTH   = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  // Core write port
  input  logic        io_wen,
  input  logic [31:0] io_waddr,
  input  logic [31:0] io_wdata,
  input  logic [3:0]  io_wstrb,
  // Core read port
  input  logic        io_ren,
  input  logic [31:0] io_raddr,
  output logic [31:0] io_rdata,
  // Board pins
  output logic        led,
  output logic [7:0]  gpio,
  output logic        uart_tx
);

  // Decoded writes to the register and queue stages
  io_wr_if wr_bus ();

  // Queue to serializer handshake
  logic       tx_valid;
  logic [7:0] tx_data;
  logic       tx_ready;

  // Flags for the status word
  logic       q_not_full;
  logic       q_empty;
  logic       q_overflow;
  logic       tx_busy;

  io_write_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .io_wen   (io_wen),
    .io_waddr (io_waddr),
    .io_wdata (io_wdata),
    .io_wstrb (io_wstrb),
    .wr       (wr_bus.src)
  );

  io_ctrl_regs #(
    .CLOCK_FREQ (CLOCK_FREQ),
    .MEM_TYPE   (MEM_TYPE)
  ) u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr         (wr_bus.regs),
    .io_ren     (io_ren),
    .io_raddr   (io_raddr),
    .q_not_full (q_not_full),
    .q_empty    (q_empty),
    .q_overflow (q_overflow),
    .tx_busy    (tx_busy),
    .io_rdata   (io_rdata),
    .led        (led),
    .gpio       (gpio)
  );

  uart_tx_queue #(
    .TX_DEPTH (TX_DEPTH)
  ) u_queue (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr             (wr_bus.queue),
    .tx_valid       (tx_valid),
    .tx_data        (tx_data),
    .tx_ready       (tx_ready),
    .not_full       (q_not_full),
    .empty          (q_empty),
    .overflow_pulse (q_overflow)
  );

  uart_tx_serializer #(
    .CLOCK_FREQ (CLOCK_FREQ),
    .BAUD_RATE  (BAUD_RATE)
  ) u_serializer (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_ready (tx_ready),
    .busy     (tx_busy),
    .uart_tx  (uart_tx)
  );

endmodule

/* test/uart_rx_monitor.sv */
module uart_rx_monitor #(
  parameter int CYCLES_PER_BIT = 8
) (
  input  logic       clk,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // Bits collected for the current frame
  logic [7:0] data_bits;

  // Samples on the falling clock edge
  // The line only moves on rising edges
  initial begin
    rx_byte  = 8'h00;
    rx_valid = 1'b0;
    forever begin
      @(negedge rx);
      // Middle of the start bit
      repeat (CYCLES_PER_BIT / 2) @(negedge clk);
      if (rx == 1'b0) begin
        // Data bits, LSB first
        for (int i = 0; i < 8; i++) begin
          repeat (CYCLES_PER_BIT) @(negedge clk);
          data_bits[i] = rx;
        end
        repeat (CYCLES_PER_BIT) @(negedge clk);
        // A framing error drops the byte
        // The checker then reports it missing
        if (rx == 1'b1) begin
          rx_byte  = data_bits;
          rx_valid = 1'b1;
          // One clock wide so exactly one rising edge sees it
          @(negedge clk);
          rx_valid = 1'b0;
        end
      end
    end
  end

endmodule

/* test/soc_io_tb.sv */
module soc_io_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLOCK_FREQ   = 1_000_000;
  localparam int BAUD_RATE    = 125_000;
  localparam int BIT_CYCLES   = CLOCK_FREQ / BAUD_RATE;
  // Start, eight data bits, stop
  localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
  // The burst test is the longest at about 600 cycles
  // Whole run stays well under this limit
  localparam int MAX_CYCLES   = 5000;

  logic        clk, rst_n, io_wen, io_ren, led, uart_tx, rx_valid;
  logic [31:0] io_waddr, io_wdata, io_raddr, io_rdata;
  logic [3:0]  io_wstrb;
  logic [7:0]  gpio, rx_byte;
  // Upper address bits that the decode stage ignores
  logic [23:0] addr_hi;
  // Value the gpio pins should hold after the last write
  logic [7:0]  gpio_exp;
  // Bytes seen on the wire in arrival order
  logic [7:0]  rx_q [$];
  int          errors, checks, cycles;

  soc_io_top #(
    .CLOCK_FREQ (CLOCK_FREQ),
    .BAUD_RATE  (BAUD_RATE),
    .MEM_TYPE   (soc_io_pkg::mem_bram),
    .TX_DEPTH   (4)
  ) dut (.*);

  uart_rx_monitor #(.CYCLES_PER_BIT (BIT_CYCLES)) u_rx_mon (
    .clk (clk), .rx (uart_tx), .rx_byte (rx_byte), .rx_valid (rx_valid)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Hang guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (rx_valid) begin
      rx_q.push_back(rx_byte);
    end
  end

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Status word built from the documented bit positions
  function automatic logic [31:0] expected_status(input logic ready, input logic idle,
                                                  input logic ovf);
    logic [31:0] w;
    w = 32'h0;
    w[soc_io_pkg::stat_tx_ready]    = ready;
    w[soc_io_pkg::stat_tx_idle]     = idle;
    w[soc_io_pkg::stat_tx_overflow] = ovf;
    return w;
  endfunction

  // Ends just after a falling edge where outputs are settled
  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic bus_write(input logic [7:0] offset, input logic [31:0] data,
                           input logic [3:0] strb);
    @(posedge clk);
    io_wen   <= 1'b1;
    io_waddr <= {addr_hi, offset};
    io_wdata <= data;
    io_wstrb <= strb;
    @(posedge clk);
    io_wen   <= 1'b0;
  endtask

  // Registered read with data valid after the sampling edge
  task automatic bus_read(input logic [7:0] offset, output logic [31:0] data);
    @(posedge clk);
    io_ren   <= 1'b1;
    io_raddr <= {addr_hi, offset};
    @(posedge clk);
    io_ren   <= 1'b0;
    @(negedge clk);
    data = io_rdata;
  endtask

  task automatic wait_bytes(input int count, input int limit);
    int n;
    n = 0;
    while (rx_q.size() < count && n < limit) begin
      @(negedge clk);
      n++;
    end
  endtask

  task automatic check_rx(input string what, input logic [7:0] exp);
    logic [7:0] got;
    if (rx_q.size() == 0) begin
      checks++;
      errors++;
      $display("No UART byte was received for %s", what);
    end else begin
      got = rx_q.pop_front();
      check_word(what, {24'h0, got}, {24'h0, exp});
    end
  endtask

  task automatic test_reset_values();
    logic [31:0] rd;
    // Let the release edge settle
    idle_cycles(1);
    check_word("led after reset", {31'h0, led}, 32'h0);
    check_word("gpio after reset", {24'h0, gpio}, 32'h0);
    check_word("uart_tx after reset", {31'h0, uart_tx}, 32'h1);
    bus_read(soc_io_pkg::reg_uart_status, rd);
    check_word("status after reset", rd, expected_status(1'b1, 1'b1, 1'b0));
    bus_read(soc_io_pkg::reg_clk_freq, rd);
    check_word("clock frequency", rd, CLOCK_FREQ);
  endtask

  task automatic test_led_gpio();
    logic [31:0] led_val, gpio_val, rd;
    // Bit 0 set so both pins move away from their reset value
    led_val  = $urandom | 32'h1;
    gpio_val = $urandom | 32'h1;
    bus_write(soc_io_pkg::reg_led, led_val, 4'hF);
    bus_write(soc_io_pkg::reg_gpio, gpio_val, 4'h1);
    idle_cycles(2);
    check_word("led pin", {31'h0, led}, {31'h0, led_val[0]});
    check_word("gpio pins", {24'h0, gpio}, {24'h0, gpio_val[7:0]});
    bus_read(soc_io_pkg::reg_led, rd);
    check_word("led readback", rd, {31'h0, led_val[0]});
    bus_read(soc_io_pkg::reg_gpio, rd);
    check_word("gpio readback", rd, {24'h0, gpio_val[7:0]});
    // Both writes are ignored with lane 0 off
    bus_write(soc_io_pkg::reg_led, ~led_val, 4'hE);
    bus_write(soc_io_pkg::reg_gpio, ~gpio_val, 4'hE);
    idle_cycles(2);
    check_word("led with lane 0 off", {31'h0, led}, {31'h0, led_val[0]});
    check_word("gpio with lane 0 off", {24'h0, gpio}, {24'h0, gpio_val[7:0]});
    gpio_exp = gpio_val[7:0];
    bus_read(8'h14, rd);
    check_word("unmapped offset", rd, 32'h0);
    bus_read(soc_io_pkg::reg_uart_data, rd);
    check_word("data offset", rd, 32'h0);
  endtask

  task automatic test_address_alias();
    logic [7:0] val;
    // Always differs from the current pins
    val     = gpio_exp ^ (8'($urandom) | 8'h01);
    addr_hi = 24'($urandom) | 24'h1;
    bus_write(soc_io_pkg::reg_gpio, {24'h0, val}, 4'h1);
    addr_hi = 24'h0;
    idle_cycles(2);
    check_word("gpio via aliased address", {24'h0, gpio}, {24'h0, val});
    gpio_exp = val;
  endtask

  task automatic test_single_byte();
    logic [7:0]  b;
    logic [31:0] rd;
    b = 8'($urandom);
    bus_write(soc_io_pkg::reg_uart_data, {24'h0, b}, 4'h1);
    wait_bytes(1, 2 * FRAME_CYCLES);
    check_rx("single UART byte", b);
    // Monitor reports at mid stop bit
    // Wait for the frame to end
    idle_cycles(BIT_CYCLES);
    bus_read(soc_io_pkg::reg_uart_status, rd);
    check_word("status after one frame", rd, expected_status(1'b1, 1'b1, 1'b0));
  endtask

  task automatic test_burst_overflow();
    logic [7:0]  b [6];
    logic [31:0] rd;
    // The first goes to the serializer and four fill the queue
    // The last one is dropped
    for (int i = 0; i < 6; i++) begin
      b[i] = 8'($urandom);
      bus_write(soc_io_pkg::reg_uart_data, {24'h0, b[i]}, 4'h1);
    end
    idle_cycles(2);
    bus_read(soc_io_pkg::reg_uart_status, rd);
    check_word("status with full queue", rd, expected_status(1'b0, 1'b0, 1'b1));
    bus_write(soc_io_pkg::reg_uart_status, 32'h0, 4'h1);
    idle_cycles(2);
    bus_read(soc_io_pkg::reg_uart_status, rd);
    check_word("status after clear", rd, expected_status(1'b0, 1'b0, 1'b0));
    wait_bytes(5, 6 * FRAME_CYCLES);
    for (int i = 0; i < 5; i++) begin
      check_rx($sformatf("burst byte %0d", i), b[i]);
    end
    // A sixth frame would have been seen by now
    idle_cycles(FRAME_CYCLES + BIT_CYCLES);
    check_word("bytes after the burst", 32'(rx_q.size()), 32'h0);
    bus_read(soc_io_pkg::reg_uart_status, rd);
    check_word("status after the burst", rd, expected_status(1'b1, 1'b1, 1'b0));
  endtask

  task automatic test_read_timing();
    logic [7:0] val;
    // Nonzero so that it differs from an idle read
    val = 8'($urandom) | 8'h01;
    bus_write(soc_io_pkg::reg_gpio, {24'h0, val}, 4'h1);
    gpio_exp = val;
    idle_cycles(2);
    @(posedge clk);
    io_ren   <= 1'b1;
    io_raddr <= {24'h0, soc_io_pkg::reg_gpio};
    @(negedge clk);
    check_word("read data before sampling", io_rdata, 32'h0);
    @(posedge clk);
    io_ren <= 1'b0;
    @(negedge clk);
    check_word("read data one cycle later", io_rdata, {24'h0, val});
    @(negedge clk);
    check_word("read data with io_ren low", io_rdata, 32'h0);
  endtask

  initial begin
    void'($urandom(32'hdedbb211));
    errors   = 0;
    checks   = 0;
    cycles   = 0;
    addr_hi  = 24'h0;
    gpio_exp = 8'h00;
    rst_n    = 1'b0;
    io_wen   = 1'b0;
    io_waddr = 32'h0;
    io_wdata = 32'h0;
    io_wstrb = 4'h0;
    io_ren   = 1'b0;
    io_raddr = 32'h0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_values();
    test_led_gpio();
    test_address_alias();
    test_single_byte();
    test_burst_overflow();
    test_read_timing();
    $display("Summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
hw/soc_io_pkg.sv
hw/io_wr_if.sv
hw/io_write_decode.sv
hw/io_ctrl_regs.sv
hw/uart_tx_queue.sv
hw/uart_tx_serializer.sv
hw/soc_io_top.sv
test/uart_rx_monitor.sv
test/soc_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
  --top-module soc_io_tb -o soc_io_sim
./obj_dir/soc_io_sim | tee sim.log
if grep -q "Regression failed" sim.log; then
  exit 1
fi
# A run that ended without a verdict is a failure too
grep -q "Regression passed" sim.log
